// File: hw/mcPkg.sv
// Shared widths and enums for states, opcodes, funct codes, ALU ops and datapath selects
package mcPkg;

	localparam int dataWidth = 32; // Word width
	localparam int regAddrWidth = 5; // Register index width

	// Control states
	typedef enum logic [3:0]
	{
		stFetchReq,
		stFetchWait,
		stDecode,
		stExecR,
		stExecI,
		stExecBranch,
		stExecJump,
		stMemAddr,
		stMemReq,
		stMemWait,
		stWriteAlu,
		stWriteMem,
		stWriteTime
	} stateT;

	// Primary opcodes, MIPS encodings
	typedef enum logic [5:0]
	{
		opRType = 6'h00,
		opJ = 6'h02,
		opBeq = 6'h04,
		opAddi = 6'h08,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcodeT;

	// R-type funct codes; timer reads sit on the mfhi/mflo slots
	typedef enum logic [5:0]
	{
		fnRdTimeHi = 6'h10,
		fnRdTimeLo = 6'h12,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [1:0] {aluAdd, aluSub, aluByFunct} aluOpT; // ALU op kind from FSM
	typedef enum logic [1:0] {srcRegB, srcFour, srcSignImm, srcBranchOff} aluSrcBT;
	typedef enum logic [1:0] {wbAluOut, wbMdr, wbTimeLo, wbTimeHi} wbSelT; // Reg write source

endpackage

// File: hw/aluUnit.sv
// Integer ALU with ALU-op and funct decode: add, sub, and, or, signed slt
`timescale 1ns/10ps

module aluUnit
	import mcPkg::*;
(
	input logic [dataWidth-1:0] a,
	input logic [dataWidth-1:0] b,
	input aluOpT aluOp, // Requested by FSM
	input functT funct, // Used for aluByFunct only
	output logic [dataWidth-1:0] result,
	output logic zero
);

	functT opSel; // Resolved operation
	logic lessThan;

	// FSM override beats the funct field
	always_comb
	begin
		case (aluOp)
			aluAdd: opSel = fnAdd; // PC + 4, addresses, addi
			aluSub: opSel = fnSub; // beq compare
			default: opSel = funct;
		endcase
	end

	assign lessThan = $signed(a) < $signed(b);

	always_comb
	begin
		case (opSel)
			fnAdd:
				result = a + b;
			fnSub:
				result = a - b;
			fnAnd:
				result = a & b;
			fnOr:
				result = a | b;
			fnSlt:
				result = {{(dataWidth-1){1'b0}}, lessThan};
			default:
				result = a + b; // Timer reads bypass the ALU
		endcase
	end

	assign zero = (result == '0);

endmodule

// File: hw/regFile.sv
// 32-entry register bank, two read ports, one write port, view port
`timescale 1ns/10ps

module regFile
	import mcPkg::*;
(
	input logic iCLK,
	input logic iRST,
	input logic [regAddrWidth-1:0] readAddr1,
	input logic [regAddrWidth-1:0] readAddr2,
	input logic [regAddrWidth-1:0] writeAddr,
	input logic [dataWidth-1:0] writeData,
	input logic regWrite,
	output logic [dataWidth-1:0] rData1,
	output logic [dataWidth-1:0] rData2,
	input logic [regAddrWidth-1:0] regSel,
	output logic [dataWidth-1:0] regView
);

	localparam int regCount = 2 ** regAddrWidth;

	logic [dataWidth-1:0] regs [regCount];

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			for (int i = 0; i < regCount; i++)
				regs[i] <= '0;
		end
		else if (regWrite && (writeAddr != '0))
			regs[writeAddr] <= writeData; // $zero never written
	end

	// Combinational reads
	assign rData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
	assign rData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];
	assign regView = (regSel == '0) ? '0 : regs[regSel];

	// Reset plus write gating keep $zero clear
	assert property (@(posedge iCLK) disable iff (iRST) regs[0] == '0);

endmodule

// File: hw/cycleTimer.sv
// Free-running 64-bit cycle counter with high-word capture register
`timescale 1ns/10ps

module cycleTimer
	import mcPkg::*;
(
	input logic iCLK,
	input logic iRST,
	input logic timeCapture, // Low word read in progress
	output logic [dataWidth-1:0] timeLo,
	output logic [dataWidth-1:0] timeHi
);

	logic [2*dataWidth-1:0] count;
	logic [dataWidth-1:0] hiHold; // High half as of last low read

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			count <= '0;
			hiHold <= '0;
		end
		else
		begin
			count <= count + 1'b1; // One tick per clock
			if (timeCapture)
				hiHold <= count[2*dataWidth-1:dataWidth];
		end
	end

	assign timeLo = count[dataWidth-1:0]; // Live low word
	assign timeHi = hiHold; // Pairs with the captured low word

endmodule

// File: hw/controlFsm.sv
// Control FSM: state register, opcode and funct decode, fetch and memory handshake sequencing
`timescale 1ns/10ps

module controlFsm
	import mcPkg::*;
(
	input logic iCLK,
	input logic iRST,
	input opcodeT opcode, // From IR
	input functT funct,
	input logic memAck,
	output logic pcWrite,
	output logic pcWriteBeq,
	output logic irWrite,
	output logic mdrWrite,
	output logic regWrite,
	output logic regDst, // 1 selects rd, 0 rt
	output logic aluSrcA, // 0 PC, 1 A
	output aluSrcBT aluSrcB,
	output aluOpT aluOp,
	output logic [1:0] pcSrc, // 0 ALU result, 1 ALUOut, 2 jump target
	output wbSelT wbSel,
	output logic timeCapture,
	output logic memReq,
	output logic memWe,
	output logic iorD, // 1 puts ALUOut on the address
	output stateT state
);

	stateT nextState;
	logic isTimeRead;
	logic isAluFunct;

	assign isTimeRead = (funct == fnRdTimeLo) || (funct == fnRdTimeHi);
	assign isAluFunct = funct inside {fnAdd, fnSub, fnAnd, fnOr, fnSlt};

	always_ff @(posedge iCLK)
	begin
		if (iRST)
			state <= stFetchReq;
		else
			state <= nextState;
	end

	always_comb
	begin
		nextState = state; // Wait states hold
		pcWrite = 1'b0;
		pcWriteBeq = 1'b0;
		irWrite = 1'b0;
		mdrWrite = 1'b0;
		regWrite = 1'b0;
		regDst = 1'b0;
		aluSrcA = 1'b1;
		aluSrcB = srcSignImm; // A + imm, keeps ALUOut steady in memory states
		aluOp = aluAdd;
		pcSrc = 2'd0;
		wbSel = wbAluOut;
		timeCapture = 1'b0;
		memReq = 1'b0;
		iorD = 1'b0;
		case (state)
			stFetchReq:
			begin
				memReq = !memAck && !iRST; // Old ack has to drop first, bus idle in reset
				if (!memAck)
					nextState = stFetchWait;
			end
			stFetchWait:
			begin
				memReq = 1'b1;
				aluSrcA = 1'b0;
				aluSrcB = srcFour;
				if (memAck)
				begin
					irWrite = 1'b1;
					pcWrite = 1'b1; // PC + 4 from ALU
					nextState = stDecode;
				end
			end
			stDecode:
			begin
				aluSrcA = 1'b0;
				aluSrcB = srcBranchOff; // Speculative branch target into ALUOut
				case (opcode)
					opRType: nextState = stExecR;
					opAddi: nextState = stExecI;
					opLw, opSw: nextState = stMemAddr;
					opBeq: nextState = stExecBranch;
					opJ: nextState = stExecJump;
					default: nextState = stFetchReq; // Unknown opcode, skip
				endcase
			end
			stExecR:
			begin
				aluSrcB = srcRegB;
				aluOp = aluByFunct;
				if (isTimeRead)
					nextState = stWriteTime;
				else if (isAluFunct)
					nextState = stWriteAlu;
				else
					nextState = stFetchReq; // Unused funct
			end
			stExecI:
				nextState = stWriteAlu; // A + imm
			stExecBranch:
			begin
				aluSrcB = srcRegB;
				aluOp = aluSub; // Zero flag means equal
				pcWriteBeq = 1'b1;
				pcSrc = 2'd1;
				nextState = stFetchReq;
			end
			stExecJump:
			begin
				pcWrite = 1'b1;
				pcSrc = 2'd2;
				nextState = stFetchReq;
			end
			stMemAddr:
				nextState = stMemReq; // Address lands in ALUOut
			stMemReq:
			begin
				iorD = 1'b1;
				memReq = !memAck;
				if (!memAck)
					nextState = stMemWait;
			end
			stMemWait:
			begin
				iorD = 1'b1;
				memReq = 1'b1;
				if (memAck)
				begin
					mdrWrite = (opcode == opLw);
					nextState = (opcode == opLw) ? stWriteMem : stFetchReq;
				end
			end
			stWriteAlu:
			begin
				regWrite = 1'b1;
				regDst = (opcode == opRType); // addi writes rt
				nextState = stFetchReq;
			end
			stWriteMem:
			begin
				regWrite = 1'b1;
				wbSel = wbMdr;
				nextState = stFetchReq;
			end
			stWriteTime:
			begin
				regWrite = 1'b1;
				regDst = 1'b1;
				wbSel = (funct == fnRdTimeLo) ? wbTimeLo : wbTimeHi;
				timeCapture = (funct == fnRdTimeLo); // Freeze high word with low read
				nextState = stFetchReq;
			end
			default:
				nextState = stFetchReq;
		endcase
		memWe = memReq && iorD && (opcode == opSw); // Stores only in data phase
	end

	// Four-phase rule, no new request over a stale ack
	assert property (@(posedge iCLK) disable iff (iRST) $rose(memReq) |-> !memAck);

	// Undefined opcode falls back to fetch
	assert property (@(posedge iCLK) disable iff (iRST)
		(state == stDecode && !(opcode inside {opRType, opAddi, opLw, opSw, opBeq, opJ}))
		|=> (state == stFetchReq));

endmodule

// File: hw/datapath.sv
// Datapath: PC, IR, A, B, MDR, ALUOut, immediate and jump formers, operand/PC/writeback muxes
`timescale 1ns/10ps

module datapath
	import mcPkg::*;
#(
	parameter logic [dataWidth-1:0] resetPc = '0
)
(
	input logic iCLK,
	input logic iRST,
	input logic pcWrite,
	input logic pcWriteBeq,
	input logic irWrite,
	input logic mdrWrite,
	input logic regWrite,
	input logic regDst,
	input logic aluSrcA,
	input aluSrcBT aluSrcB,
	input aluOpT aluOp,
	input logic [1:0] pcSrc,
	input wbSelT wbSel,
	input logic iorD,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWData,
	input logic [dataWidth-1:0] memRData,
	input logic [dataWidth-1:0] timeLo,
	input logic [dataWidth-1:0] timeHi,
	output opcodeT opcode,
	output functT funct,
	output logic zero,
	input logic [regAddrWidth-1:0] regSel,
	output logic [dataWidth-1:0] regView,
	output logic [dataWidth-1:0] pc
);

	logic [dataWidth-1:0] pcReg, ir, a, b, mdr, aluOut;
	logic [dataWidth-1:0] rData1, rData2;
	logic [dataWidth-1:0] signImm, branchOff, jumpTarget;
	logic [dataWidth-1:0] aluA, aluB, aluResult, pcNext, wbData;
	logic [regAddrWidth-1:0] writeAddr;

	// Instruction fields
	assign opcode = opcodeT'(ir[31:26]);
	assign funct = functT'(ir[5:0]);
	assign signImm = {{(dataWidth-16){ir[15]}}, ir[15:0]};
	assign branchOff = {{(dataWidth-18){ir[15]}}, ir[15:0], 2'b00}; // Word offset
	assign jumpTarget = {pcReg[dataWidth-1:dataWidth-4], ir[25:0], 2'b00}; // PC already +4
	assign writeAddr = regDst ? ir[15:11] : ir[20:16];

	always_ff @(posedge iCLK)
	begin
		if (iRST)
		begin
			pcReg <= resetPc;
			ir <= '0; // Decodes as a nop
		end
		else
		begin
			if (pcWrite || (pcWriteBeq && zero))
				pcReg <= pcNext;
			if (irWrite)
				ir <= memRData;
		end
	end

	// Temporaries reload every cycle, MDR only on load ack
	always_ff @(posedge iCLK)
	begin
		a <= rData1;
		b <= rData2;
		aluOut <= aluResult;
		if (mdrWrite)
			mdr <= memRData;
	end

	assign aluA = aluSrcA ? a : pcReg;

	always_comb
	begin
		case (aluSrcB)
			srcRegB: aluB = b;
			srcFour: aluB = dataWidth'(4);
			srcSignImm: aluB = signImm;
			default: aluB = branchOff;
		endcase
	end

	always_comb
	begin
		case (pcSrc)
			2'd1: pcNext = aluOut; // Branch target from decode
			2'd2: pcNext = jumpTarget;
			default: pcNext = aluResult; // PC + 4
		endcase
	end

	always_comb
	begin
		case (wbSel)
			wbMdr: wbData = mdr;
			wbTimeLo: wbData = timeLo;
			wbTimeHi: wbData = timeHi;
			default: wbData = aluOut;
		endcase
	end

	assign memAddr = iorD ? aluOut : pcReg; // Shared instruction/data bus
	assign memWData = b;
	assign pc = pcReg;

	regFile regs (
		.iCLK(iCLK),
		.iRST(iRST),
		.readAddr1(ir[25:21]), // rs
		.readAddr2(ir[20:16]), // rt
		.writeAddr(writeAddr),
		.writeData(wbData),
		.regWrite(regWrite),
		.rData1(rData1),
		.rData2(rData2),
		.regSel(regSel),
		.regView(regView)
	);

	aluUnit alu (
		.a(aluA),
		.b(aluB),
		.aluOp(aluOp),
		.funct(funct),
		.result(aluResult),
		.zero(zero)
	);

endmodule

// File: hw/mcCpu.sv
// Top level: control FSM, datapath and cycle timer on the four-phase memory bus
`timescale 1ns/10ps

module mcCpu
	import mcPkg::*;
#(
	parameter logic [dataWidth-1:0] resetPc = '0 // First fetch address
)
(
	input logic iCLK,
	input logic iRST,
	output logic memReq,
	output logic memWe,
	output logic [dataWidth-1:0] memAddr,
	output logic [dataWidth-1:0] memWData,
	input logic memAck,
	input logic [dataWidth-1:0] memRData,
	input logic [regAddrWidth-1:0] regSel, // Register view select
	output logic [dataWidth-1:0] regView,
	output logic [dataWidth-1:0] pc,
	output stateT state
);

	logic pcWrite, pcWriteBeq, irWrite, mdrWrite, regWrite, regDst, aluSrcA;
	logic iorD, timeCapture;
	logic [1:0] pcSrc;
	aluSrcBT aluSrcB;
	aluOpT aluOp;
	wbSelT wbSel;
	opcodeT opcode;
	functT funct;
	logic [dataWidth-1:0] timeLo, timeHi;

	controlFsm ctrl (
		.iCLK(iCLK), .iRST(iRST),
		.opcode(opcode), .funct(funct), .memAck(memAck),
		.pcWrite(pcWrite), .pcWriteBeq(pcWriteBeq), .irWrite(irWrite),
		.mdrWrite(mdrWrite), .regWrite(regWrite), .regDst(regDst),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp),
		.pcSrc(pcSrc), .wbSel(wbSel), .timeCapture(timeCapture),
		.memReq(memReq), .memWe(memWe), .iorD(iorD), .state(state)
	);

	datapath #(.resetPc(resetPc)) dp (
		.iCLK(iCLK), .iRST(iRST),
		.pcWrite(pcWrite), .pcWriteBeq(pcWriteBeq), .irWrite(irWrite),
		.mdrWrite(mdrWrite), .regWrite(regWrite), .regDst(regDst),
		.aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluOp(aluOp),
		.pcSrc(pcSrc), .wbSel(wbSel), .iorD(iorD),
		.memAddr(memAddr), .memWData(memWData), .memRData(memRData),
		.timeLo(timeLo), .timeHi(timeHi),
		.opcode(opcode), .funct(funct), .zero(),
		.regSel(regSel), .regView(regView), .pc(pc)
	);

	cycleTimer timer (
		.iCLK(iCLK), .iRST(iRST),
		.timeCapture(timeCapture),
		.timeLo(timeLo), .timeHi(timeHi)
	);

endmodule

// File: sim/memResponder.sv
// Testbench memory: four-phase bus responder with random ack delay, word array and store log
`timescale 1ns/10ps

module memResponder
#(
	parameter int words = 256,
	parameter int seedInit = 32'h8201_78fa
)
(
	input logic iCLK,
	input logic iRST,
	input logic memReq,
	input logic memWe,
	input logic [31:0] memAddr,
	input logic [31:0] memWData,
	output logic memAck = 1'b0,
	output logic [31:0] memRData = '0
);

	localparam int idxBits = $clog2(words);

	logic [31:0] mem [words]; // Loaded by the testbench before reset release
	logic [31:0] storeAddrLog [$]; // Every store seen on the bus, in order
	logic [31:0] storeDataLog [$];

	logic rstS = 1'b1;
	logic reqS = 1'b0;
	logic weS = 1'b0;
	logic [31:0] addrS = '0;
	logic [31:0] dataS = '0;
	int seed = seedInit;
	int delay = 0; // Cycles left before the ack
	logic pending = 1'b0;

	// Bus seen as the core's flops see it
	always @(posedge iCLK)
	begin
		rstS <= iRST;
		reqS <= memReq;
		weS <= memWe;
		addrS <= memAddr;
		dataS <= memWData;
	end

	// Outputs change on the falling edge only
	always @(negedge iCLK)
	begin
		if (rstS)
		begin
			memAck <= 1'b0;
			pending = 1'b0;
		end
		else if (memAck)
		begin
			if (!reqS)
				memAck <= 1'b0; // Release seen, close the handshake
		end
		else if (reqS)
		begin
			if (!pending)
			begin
				pending = 1'b1;
				delay = $unsigned($random(seed)) % 6; // 0 to 5 wait cycles
			end
			if (delay == 0)
			begin
				pending = 1'b0;
				memAck <= 1'b1;
				if (weS)
				begin
					mem[addrS[idxBits+1:2]] = dataS;
					storeAddrLog.push_back(addrS);
					storeDataLog.push_back(dataS);
				end
				else
					memRData <= mem[addrS[idxBits+1:2]]; // Valid while ack is high
			end
			else
				delay = delay - 1;
		end
	end

endmodule

// File: sim/mcCpuTb.sv
// Testbench top: random program, ISA reference model, bus monitor, watchdog and summary
`timescale 1ns/10ps

module mcCpuTb
	import mcPkg::*;
();

	localparam logic [31:0] resetPc = 32'h0000_0040; // Program start
	localparam int progLen = 60;
	localparam int memWords = 256;
	localparam int dataBase = 32'h200; // 64-word data region
	localparam int cyclesPerInstr = 30; // Worst case with slow acks
	localparam int periodNs = 100;
	localparam logic [31:0] endAddr = resetPc + 4 * (progLen - 1); // Jump-to-self

	logic iCLK = 1'b0;
	logic iRST = 1'b1;
	logic [4:0] regSel = '0;
	logic memReq, memWe, memAck;
	logic [31:0] memAddr, memWData, memRData, regView, pc;
	stateT state;

	logic [31:0] prog [progLen];
	logic [31:0] modelMem [memWords];
	logic [31:0] modelRegs [32];
	logic [31:0] modelStoreAddr [$];
	logic [31:0] modelStoreData [$];
	int seed = 32'h8201_78fa;
	int testErrors [5] = '{default: 0};
	int errorCount = 0;
	int endFetches = 0; // Acked fetches of the final jump
	int resetEdges = 0;
	bit firstReqSeen = 1'b0;
	logic prevReq = 1'b0;
	logic prevAck = 1'b0;
	logic prevWe = 1'b0;
	logic [31:0] prevAddr = '0;
	logic [31:0] prevData = '0;
	string testNames [5] = '{"reset and first fetch", "bus handshake", "store sequence",
		"register contents", "timer reads"};

	always #(periodNs / 2) iCLK = ~iCLK;

	mcCpu #(.resetPc(resetPc)) uut (
		.iCLK(iCLK), .iRST(iRST),
		.memReq(memReq), .memWe(memWe), .memAddr(memAddr), .memWData(memWData),
		.memAck(memAck), .memRData(memRData),
		.regSel(regSel), .regView(regView), .pc(pc), .state(state)
	);

	memResponder #(.words(memWords)) ram (
		.iCLK(iCLK), .iRST(iRST),
		.memReq(memReq), .memWe(memWe), .memAddr(memAddr), .memWData(memWData),
		.memAck(memAck), .memRData(memRData)
	);

	// Instruction encoders, MIPS field layout
	function automatic logic [31:0] rInstr(logic [4:0] rs, logic [4:0] rt, logic [4:0] rd,
		functT fn);
		return {opRType, rs, rt, rd, 5'h00, fn};
	endfunction

	function automatic logic [31:0] iInstr(opcodeT op, logic [4:0] rs, logic [4:0] rt,
		logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jInstr(logic [25:0] index);
		return {opJ, index};
	endfunction

	// Background memory contents, a function of the byte address
	function automatic logic [31:0] fillWord(int unsigned index);
		logic [31:0] addr;
		addr = index * 4;
		return (addr * 32'h9e37_79b9) ^ {addr[15:0], addr[31:16]} ^ 32'hc3a5_5a3c;
	endfunction

	task automatic noteError(int test, string msg);
		$display("%s", msg);
		testErrors[test]++;
		errorCount++;
	endtask

	task automatic reportTest(int test);
		if (testErrors[test] == 0)
			$display("Test %0d, %s: ok", test + 1, testNames[test]);
		else
			$display("Test %0d, %s: %0d errors", test + 1, testNames[test], testErrors[test]);
	endtask

	task automatic buildProgram;
		int pick, rs, rt, rd, word, skip, maxSkip;
		logic [31:0] rnd;
		functT aluFns [5] = '{fnAdd, fnSub, fnAnd, fnOr, fnSlt};
		for (int i = 0; i < 15; i++)
		begin
			rnd = $random(seed);
			prog[i] = iInstr(opAddi, 5'd0, 5'(i + 1), rnd[15:0]); // r1..r15 seeds
		end
		prog[15] = rInstr(5'd0, 5'd0, 5'd16, fnRdTimeLo); // Back-to-back timer reads
		prog[16] = rInstr(5'd0, 5'd0, 5'd17, fnRdTimeLo);
		prog[17] = rInstr(5'd0, 5'd0, 5'd18, fnRdTimeHi);
		prog[18] = iInstr(opAddi, 5'd0, 5'd20, 16'(dataBase)); // Data pointer in r20
		for (int i = 19; i < progLen - 1; i++)
		begin
			pick = $unsigned($random(seed)) % 8;
			rs = $unsigned($random(seed)) % 16;
			rt = 1 + $unsigned($random(seed)) % 15;
			rd = 1 + $unsigned($random(seed)) % 15;
			word = $unsigned($random(seed)) % 64;
			case (pick)
				0, 1, 2:
					prog[i] = rInstr(5'(rs), 5'(rt), 5'(rd), aluFns[$unsigned($random(seed)) % 5]);
				3:
					prog[i] = iInstr(opLw, 5'd20, 5'(rt), 16'(word * 4));
				4:
					prog[i] = iInstr(opSw, 5'd20, 5'(rt), 16'(word * 4));
				5, 6:
				begin
					maxSkip = progLen - 2 - i; // Target stays inside the program
					if (maxSkip > 3)
						maxSkip = 3;
					skip = (maxSkip > 0) ? 1 + $unsigned($random(seed)) % maxSkip : 0;
					if ($random(seed) & 1)
						rt = rs; // Forces a taken branch
					prog[i] = iInstr(opBeq, 5'(rs), 5'(rt), 16'(skip));
				end
				default:
				begin
					rnd = $random(seed);
					prog[i] = iInstr(opAddi, 5'(rs), 5'(rt), rnd[15:0]);
				end
			endcase
		end
		prog[progLen - 1] = jInstr(26'((resetPc >> 2) + progLen - 1));
	endtask

	task automatic loadMemories;
		for (int i = 0; i < memWords; i++)
		begin
			modelMem[i] = fillWord(i);
			ram.mem[i] = fillWord(i);
		end
		for (int i = 0; i < progLen; i++)
		begin
			modelMem[(resetPc >> 2) + i] = prog[i];
			ram.mem[(resetPc >> 2) + i] = prog[i];
		end
	endtask

	function automatic void writeModelReg(logic [4:0] idx, logic [31:0] value);
		if (idx != 5'd0)
			modelRegs[idx] = value;
	endfunction

	// ISA-level interpreter, stops at the jump-to-self
	task automatic runModel;
		logic [31:0] mpc, ins, rsV, rtV, imm, ea, nextPc;
		int steps;
		for (int r = 0; r < 32; r++)
			modelRegs[r] = '0;
		mpc = resetPc;
		steps = 0;
		ins = modelMem[mpc[9:2]];
		while (ins != jInstr(26'(mpc >> 2)) && steps < 1000)
		begin
			rsV = modelRegs[ins[25:21]];
			rtV = modelRegs[ins[20:16]];
			imm = {{16{ins[15]}}, ins[15:0]};
			nextPc = mpc + 4;
			case (ins[31:26])
				opRType:
					case (ins[5:0])
						fnAdd: writeModelReg(ins[15:11], rsV + rtV);
						fnSub: writeModelReg(ins[15:11], rsV - rtV);
						fnAnd: writeModelReg(ins[15:11], rsV & rtV);
						fnOr: writeModelReg(ins[15:11], rsV | rtV);
						fnSlt: writeModelReg(ins[15:11], ($signed(rsV) < $signed(rtV)) ? 1 : 0);
						default: ; // Timer values checked on their own
					endcase
				opAddi:
					writeModelReg(ins[20:16], rsV + imm);
				opLw:
				begin
					ea = rsV + imm;
					writeModelReg(ins[20:16], modelMem[ea[9:2]]);
				end
				opSw:
				begin
					ea = rsV + imm;
					modelMem[ea[9:2]] = rtV;
					modelStoreAddr.push_back(ea);
					modelStoreData.push_back(rtV);
				end
				opBeq:
					if (rsV == rtV)
						nextPc = mpc + 4 + (imm << 2);
				opJ:
					nextPc = {nextPc[31:28], ins[25:0], 2'b00};
				default: ;
			endcase
			mpc = nextPc;
			ins = modelMem[mpc[9:2]];
			steps++;
		end
	endtask

	// Bus monitor, values taken just before each rising edge
	always @(posedge iCLK)
	begin
		if (iRST)
		begin
			if (resetEdges > 0) // State known after the first edge
			begin
				if (memReq !== 1'b0 || memWe !== 1'b0)
					noteError(0, $sformatf("At %0t ns the bus was requested during reset",
						$time));
				if (pc !== resetPc)
					noteError(0, $sformatf("Fail at %0t ns: pc is %h, expected %h",
						$time, pc, resetPc));
			end
			resetEdges++;
		end
		else
		begin
			if (!firstReqSeen)
			begin
				firstReqSeen = 1'b1;
				if (memReq !== 1'b1)
					noteError(0, $sformatf("At %0t ns no fetch request after reset", $time));
				if (memWe !== 1'b0)
					noteError(0, $sformatf("At %0t ns the first request is a write", $time));
				if (memAddr !== resetPc)
					noteError(0, $sformatf("Fail at %0t ns: memAddr is %h, expected %h",
						$time, memAddr, resetPc));
				reportTest(0);
			end
			if (memReq && !prevReq && memAck)
				noteError(1, $sformatf("At %0t ns memReq rose while memAck was high", $time));
			if (memReq && prevReq && (memAddr !== prevAddr || memWe !== prevWe
				|| (memWe && memWData !== prevData)))
				noteError(1, $sformatf("At %0t ns the request changed while memReq was high",
					$time));
			if (prevReq && !prevAck && !memReq)
				noteError(1, $sformatf("At %0t ns memReq dropped before memAck", $time));
			if (state == stFetchWait && memAck && memAddr == endAddr)
				endFetches++;
		end
		prevReq = memReq;
		prevAck = memAck;
		prevWe = memWe;
		prevAddr = memAddr;
		prevData = memWData;
	end

	initial
	begin
		logic [31:0] timeVals [3];
		int unsigned elapsed;
		int passCount;
		buildProgram();
		loadMemories();
		runModel();
		repeat (4) @(negedge iCLK);
		iRST = 1'b0;
		while (endFetches < 2)
			@(posedge iCLK);

		if (ram.storeAddrLog.size() != modelStoreAddr.size())
			noteError(2, $sformatf("The bus showed %0d stores where the model made %0d",
				ram.storeAddrLog.size(), modelStoreAddr.size()));
		for (int i = 0; i < ram.storeAddrLog.size() && i < modelStoreAddr.size(); i++)
		begin
			if (ram.storeAddrLog[i] !== modelStoreAddr[i])
				noteError(2, $sformatf("Fail at %0t ns: memAddr of store %0d is %h, expected %h",
					$time, i, ram.storeAddrLog[i], modelStoreAddr[i]));
			if (ram.storeDataLog[i] !== modelStoreData[i])
				noteError(2, $sformatf("Fail at %0t ns: memWData of store %0d is %h, expected %h",
					$time, i, ram.storeDataLog[i], modelStoreData[i]));
		end
		reportTest(2);

		// Register sweep through the view port
		for (int r = 1; r < 32; r++)
		begin
			@(negedge iCLK);
			regSel = 5'(r);
			@(posedge iCLK);
			if (r >= 16 && r <= 18)
				timeVals[r - 16] = regView;
			else if (regView !== modelRegs[r])
				noteError(3, $sformatf("Fail at %0t ns: regView of r%0d is %h, expected %h",
					$time, r, regView, modelRegs[r]));
		end
		reportTest(3);

		elapsed = timeVals[1] - timeVals[0];
		if (elapsed < 5 || elapsed >= progLen * cyclesPerInstr)
			noteError(4, $sformatf("Timer reads are %0d cycles apart, outside 5 to %0d",
				elapsed, progLen * cyclesPerInstr - 1));
		if (timeVals[2] !== 32'h0)
			noteError(4, $sformatf("Fail at %0t ns: regView of r18 is %h, expected %h",
				$time, timeVals[2], 32'h0));
		reportTest(4);
		reportTest(1);

		passCount = 0;
		for (int t = 0; t < 5; t++)
			if (testErrors[t] == 0)
				passCount++;
		$display("Tests: 5, passed: %0d, failed: %0d, errors: %0d", passCount, 5 - passCount,
			errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog sized from program length and worst-case cycles per instruction
	initial
	begin
		#((4 + progLen * cyclesPerInstr + 200) * periodNs);
		$display("Timeout: the core never fetched the final jump twice");
		$display("Checks failed");
		$finish;
	end

endmodule

// File: mcCpu.f
hw/mcPkg.sv
hw/aluUnit.sv
hw/regFile.sv
hw/cycleTimer.sv
hw/controlFsm.sv
hw/datapath.sv
hw/mcCpu.sv
sim/memResponder.sv
sim/mcCpuTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run the testbench, pass only on the success line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mcCpuTb -f mcCpu.f \
	|| { echo "Build error"; exit 1; }
out="$(./obj_dir/VmcCpuTb)"
echo "$out"
echo "$out" | grep -qx "All checks passed" && echo "Result: pass" \
	|| { echo "Result: fail"; exit 1; }
